// ==== source/fetchPredictPkg.sv ====
// ==================================================
// Fetch predictor package
// Table geometry, the code address union and the
// direction counter constants shared by the design
// ==================================================

package fetchPredictPkg;

  // ==================================================
  // Table geometry
  // ==================================================

  // One entry per index in both the BTB and the counter table
  localparam int btbEntries = 1024;
  localparam int indexWidth = 10;

  // Instructions are word aligned so the low two bits never select an entry
  localparam int offsetWidth = 2;
  localparam int tagWidth = 32 - indexWidth - offsetWidth;

  // ==================================================
  // Code addresses
  // ==================================================

  // Field view of a byte address as the tables see it
  typedef struct packed {
    logic [tagWidth-1:0]    tag;
    logic [indexWidth-1:0]  index;
    logic [offsetWidth-1:0] offset;
  } codeFields_t;

  // A code address is either used whole or split for table access
  typedef union packed {
    logic [31:0] raw;
    codeFields_t fields;
  } codeAddr_u;

  // Step to the next sequential instruction
  localparam logic [31:0] fallThrough = 32'd4;

  // ==================================================
  // Direction counters
  // ==================================================

  // Cleared counters start weakly not taken
  localparam logic [1:0] ctrInit = 2'd1;

  // Counter values from here upward predict taken
  localparam logic [1:0] ctrTakenMin = 2'd2;

endpackage

// ==== source/btbIf.sv ====
// ==================================================
// BTB interface
// Lookup and write traffic between the predictor
// control and the branch target buffer
// ==================================================

`timescale 1ns/1ns

interface btbIf import fetchPredictPkg::*; ();

  // Read side. The address is registered by the BTB when rdEn is high
  logic      rdEn;
  codeAddr_u rdIp;

  // The reset sweep and retire updates share the write side
  logic                  wrEn;
  logic [indexWidth-1:0] wrIndex;
  logic [tagWidth-1:0]   wrTag;
  codeAddr_u             wrTgt;
  logic                  wrValid;

  // Result for the registered read address
  logic      hit;
  codeAddr_u target;

  modport ctrl (
    output rdEn, rdIp, wrEn, wrIndex, wrTag, wrTgt, wrValid,
    input  hit, target
  );

  modport store (
    input  rdEn, rdIp, wrEn, wrIndex, wrTag, wrTgt, wrValid,
    output hit, target
  );

endinterface

// ==== source/counterIf.sv ====
// ==================================================
// Counter interface
// Read, update and clear traffic between the
// predictor control and the bimodal counter table
// ==================================================

`timescale 1ns/1ns

interface counterIf import fetchPredictPkg::*; ();

  logic                  rdEn;
  logic [indexWidth-1:0] rdIndex;

  // Retire update moves the counter one step toward the outcome
  logic                  updEn;
  logic [indexWidth-1:0] updIndex;
  logic                  updTaken;

  // Sweep clear after reset
  logic                  clrEn;
  logic [indexWidth-1:0] clrIndex;

  logic                  predTaken;

  modport ctrl (
    output rdEn, rdIndex, updEn, updIndex, updTaken, clrEn, clrIndex,
    input  predTaken
  );

  modport ctrTable (
    input  rdEn, rdIndex, updEn, updIndex, updTaken, clrEn, clrIndex,
    output predTaken
  );

endinterface

// ==== source/predictCtrl.sv ====
// ==================================================
// Predictor control
// Runs the post-reset table sweep, steers lookups and
// retire updates to both tables and forms the next
// fetch address from the table results
// ==================================================

`timescale 1ns/1ns

module predictCtrl import fetchPredictPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      lookupValid,
  input  codeAddr_u lookupIp,
  input  logic      updValid,
  input  codeAddr_u updIp,
  input  codeAddr_u updTgt,
  input  logic      updTaken,
  output logic      ready,
  output logic      predValid,
  output codeAddr_u predIp,
  output logic      predTaken,
  btbIf.ctrl        btb,
  counterIf.ctrl    ctr
);

  logic                  sweeping;
  logic [indexWidth-1:0] sweepIdx;
  logic                  lookupAccept;
  logic                  updAccept;
  codeAddr_u             lookupIpQ;

  // ==================================================
  // Reset sweep
  // ==================================================

  // One index is cleared per cycle starting right after reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sweeping <= 1'b1;
      sweepIdx <= '0;
    end else if (sweeping) begin
      if (sweepIdx == indexWidth'(btbEntries - 1)) begin
        sweeping <= 1'b0;
      end else begin
        sweepIdx <= sweepIdx + 1'b1;
      end
    end
  end

  // Ready rises the cycle after the last index is written
  assign ready = !sweeping;

  assign lookupAccept = lookupValid && ready;
  assign updAccept    = updValid && ready;

  // ==================================================
  // Table writes
  // ==================================================

  // The sweep owns the write ports until it finishes
  assign btb.wrEn    = sweeping || updAccept;
  assign btb.wrIndex = sweeping ? sweepIdx : updIp.fields.index;
  assign btb.wrTag   = sweeping ? '0 : updIp.fields.tag;
  assign btb.wrTgt   = sweeping ? codeAddr_u'('0) : updTgt;
  // A cleared entry is invalid and a not-taken branch drops its entry
  assign btb.wrValid = !sweeping && updTaken;

  assign ctr.clrEn    = sweeping;
  assign ctr.clrIndex = sweepIdx;
  assign ctr.updEn    = updAccept;
  assign ctr.updIndex = updIp.fields.index;
  assign ctr.updTaken = updTaken;

  // ==================================================
  // Lookup path
  // ==================================================

  // Both tables register the read address on the same edge
  assign btb.rdEn    = lookupAccept;
  assign btb.rdIp    = lookupIp;
  assign ctr.rdEn    = lookupAccept;
  assign ctr.rdIndex = lookupIp.fields.index;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      predValid <= 1'b0;
    end else begin
      predValid <= lookupAccept;
    end
  end

  // Keeps the fetch address for the fall-through sum
  always_ff @(posedge clk) begin
    if (lookupAccept) begin
      lookupIpQ <= lookupIp;
    end
  end

  // Taken only when the BTB knows the target and the counter agrees
  assign predTaken  = predValid && btb.hit && ctr.predTaken;
  assign predIp.raw = predTaken ? btb.target.raw : lookupIpQ.raw + fallThrough;

  // Neither table reports a result unless a lookup was accepted the cycle before
  assert property (@(posedge clk) disable iff (!rstN)
    !predValid |-> !btb.hit && !ctr.predTaken);

endmodule

// ==== source/branchTargetBuffer.sv ====
// ==================================================
// Branch target buffer
// Direct-mapped store of branch targets with a tag
// compare against the registered lookup address
// ==================================================

`timescale 1ns/1ns

module branchTargetBuffer import fetchPredictPkg::*; (
  input logic clk,
  input logic rstN,
  btbIf.store port
);

  // Entry storage split into fields
  logic [tagWidth-1:0] tagMem   [btbEntries];
  codeAddr_u           tgtMem   [btbEntries];
  logic                validMem [btbEntries];

  codeAddr_u           rdAddr;
  logic                rdLive;
  logic [indexWidth-1:0] rdIndex;

  // ==================================================
  // Write port
  // ==================================================

  // Sweep clears and retire updates share this one write port
  always_ff @(posedge clk) begin
    if (port.wrEn) begin
      tagMem[port.wrIndex]   <= port.wrTag;
      tgtMem[port.wrIndex]   <= port.wrTgt;
      validMem[port.wrIndex] <= port.wrValid;
    end
  end

  // ==================================================
  // Read port
  // ==================================================

  // Full address is kept for the tag compare in the next cycle
  always_ff @(posedge clk) begin
    if (port.rdEn) begin
      rdAddr <= port.rdIp;
    end
  end

  // Marks a read in flight so hit stays low while storage is unswept
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdLive <= 1'b0;
    end else begin
      rdLive <= port.rdEn;
    end
  end

  assign rdIndex = rdAddr.fields.index;

  // A write at the lookup edge is already visible here
  assign port.hit = rdLive && validMem[rdIndex] &&
                    (tagMem[rdIndex] == rdAddr.fields.tag);
  assign port.target = tgtMem[rdIndex];

  // Control must always present a defined write index
  assert property (@(posedge clk) disable iff (!rstN)
    port.wrEn |-> !$isunknown(port.wrIndex));

endmodule

// ==== source/bimodalCounters.sv ====
// ==================================================
// Bimodal direction counters
// 2-bit saturating counters, one per table index,
// updated in place on each resolved branch
// ==================================================

`timescale 1ns/1ns

module bimodalCounters import fetchPredictPkg::*; (
  input logic       clk,
  input logic       rstN,
  counterIf.ctrTable port
);

  logic [1:0]            ctrMem [btbEntries];
  logic [indexWidth-1:0] rdIndexQ;
  logic                  rdLive;
  logic [1:0]            updOld;

  assign updOld = ctrMem[port.updIndex];

  // ==================================================
  // Clear and update
  // ==================================================

  // Read-modify-write completes on a single edge
  always_ff @(posedge clk) begin
    if (port.clrEn) begin
      ctrMem[port.clrIndex] <= ctrInit;
    end else if (port.updEn) begin
      if (port.updTaken) begin
        // Strongly taken stays put
        if (updOld != 2'd3) begin
          ctrMem[port.updIndex] <= updOld + 2'd1;
        end
      end else if (updOld != 2'd0) begin
        ctrMem[port.updIndex] <= updOld - 2'd1;
      end
    end
  end

  // ==================================================
  // Read
  // ==================================================

  always_ff @(posedge clk) begin
    if (port.rdEn) begin
      rdIndexQ <= port.rdIndex;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdLive <= 1'b0;
    end else begin
      rdLive <= port.rdEn;
    end
  end

  // Upper half of the counter range predicts taken
  assign port.predTaken = rdLive && (ctrMem[rdIndexQ] >= ctrTakenMin);

  // The sweep and retire updates never share a cycle
  assert property (@(posedge clk) disable iff (!rstN) !(port.clrEn && port.updEn));

endmodule

// ==== source/fetchPredictor.sv ====
// ==================================================
// Fetch predictor top level
// BTB plus bimodal direction table behind a plain
// lookup port and a retire update port
// ==================================================

`timescale 1ns/1ns

module fetchPredictor import fetchPredictPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      lookupValid,
  input  codeAddr_u lookupIp,
  input  logic      updValid,
  input  codeAddr_u updIp,
  input  codeAddr_u updTgt,
  input  logic      updTaken,
  output logic      ready,
  output logic      predValid,
  output codeAddr_u predIp,
  output logic      predTaken
);

  // Internal buses between control and the two tables
  btbIf     btbBus ();
  counterIf ctrBus ();

  predictCtrl u_predictCtrl (
    .clk         (clk),
    .rstN        (rstN),
    .lookupValid (lookupValid),
    .lookupIp    (lookupIp),
    .updValid    (updValid),
    .updIp       (updIp),
    .updTgt      (updTgt),
    .updTaken    (updTaken),
    .ready       (ready),
    .predValid   (predValid),
    .predIp      (predIp),
    .predTaken   (predTaken),
    .btb         (btbBus.ctrl),
    .ctr         (ctrBus.ctrl)
  );

  branchTargetBuffer u_branchTargetBuffer (
    .clk  (clk),
    .rstN (rstN),
    .port (btbBus.store)
  );

  bimodalCounters u_bimodalCounters (
    .clk  (clk),
    .rstN (rstN),
    .port (ctrBus.ctrTable)
  );

endmodule

// ==== include/tbModel.svh ====
// ==================================================
// Fetch predictor reference model
// Mirror tables, expected prediction, retire update
// and the Galois LFSR for random stimulus
// ==================================================

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Mirror of the BTB entries and the direction counters
logic [tagWidth-1:0] mTag   [btbEntries];
codeAddr_u           mTgt   [btbEntries];
logic                mValid [btbEntries];
logic [1:0]          mCtr   [btbEntries];

// LFSR state that the testbench top seeds
logic [31:0] lfsrState;

// Fresh tables look like the end of a reset sweep
function automatic void modelClear();
  for (int i = 0; i < btbEntries; i++) begin
    mTag[i] = '0;
    mTgt[i].raw = '0;
    mValid[i] = 1'b0;
    mCtr[i] = 2'd1;
  end
endfunction

// A resolved branch stores its entry and nudges the counter toward the outcome
function automatic void modelUpdate(input codeAddr_u ip, input codeAddr_u tgt,
                                    input logic taken);
  logic [indexWidth-1:0] idx;
  idx = ip.fields.index;
  mTag[idx] = ip.fields.tag;
  mTgt[idx] = tgt;
  mValid[idx] = taken;
  if (taken && mCtr[idx] != 2'd3) begin
    mCtr[idx] = mCtr[idx] + 2'd1;
  end else if (!taken && mCtr[idx] != 2'd0) begin
    mCtr[idx] = mCtr[idx] - 2'd1;
  end
endfunction

// Expected next fetch address with the expected taken flag as the return value
function automatic logic refPredict(input codeAddr_u ip, output codeAddr_u nextIp);
  logic [indexWidth-1:0] idx;
  logic                  taken;
  idx = ip.fields.index;
  taken = mValid[idx] && (mTag[idx] == ip.fields.tag) && (mCtr[idx] >= 2'd2);
  nextIp.raw = taken ? mTgt[idx].raw : ip.raw + 32'd4;
  return taken;
endfunction

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step for every bit handed out
function automatic logic [31:0] randBits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsrState[0]};
    lfsrState = lfsrNext(lfsrState);
  end
  return v;
endfunction

`endif

// ==== test/fetchPredictorTb.sv ====
// ==================================================
// Fetch predictor testbench
// Reset sweep, counter and tag rules, random traffic
// and a second sweep, checked against the model
// ==================================================

`timescale 1ns/1ns

module fetchPredictorTb import fetchPredictPkg::*; ();

  localparam int resetCycles = 3;
  localparam int randomCycles = 300;
  localparam int directedCycles = 80;
  localparam logic [31:0] lfsrSeed = 32'd96248;
  // Two sweeps with their resets, all test phases and a margin
  localparam int timeoutCycles = 2 * (resetCycles + 1 + btbEntries) + directedCycles +
                                 randomCycles + 100;

  // The clock starts low before any process runs so time zero has no edge
  logic      clk = 1'b0;
  logic      rstN;
  logic      lookupValid;
  codeAddr_u lookupIp;
  logic      updValid;
  codeAddr_u updIp;
  codeAddr_u updTgt;
  logic      updTaken;
  logic      ready;
  logic      predValid;
  codeAddr_u predIp;
  logic      predTaken;

  int        errors;
  int        checks;
  int        cycleCount;
  string     testName;
  codeAddr_u addrA;
  codeAddr_u addrB;
  codeAddr_u tgtA;

  // Expected results, one entry per accepted lookup
  codeAddr_u expIpQ [$];
  logic      expTakenQ [$];

  `include "tbModel.svh"

  fetchPredictor u_fetchPredictor (
    .clk         (clk),
    .rstN        (rstN),
    .lookupValid (lookupValid),
    .lookupIp    (lookupIp),
    .updValid    (updValid),
    .updIp       (updIp),
    .updTgt      (updTgt),
    .updTaken    (updTaken),
    .ready       (ready),
    .predValid   (predValid),
    .predIp      (predIp),
    .predTaken   (predTaken)
  );

  always #50 clk = ~clk;

  // ==================================================
  // Compare tasks
  // ==================================================

  task automatic checkAddr(input string what, input codeAddr_u exp, input codeAddr_u act);
    checks++;
    if (act.raw !== exp.raw) begin
      errors++;
      $display("error %s %s: expected %h actual %h", testName, what, exp.raw, act.raw);
    end
  endtask

  task automatic checkBit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s %s: expected %b actual %b", testName, what, exp, act);
    end
  endtask

  // ==================================================
  // Compare process
  // ==================================================

  // Outputs and inputs are both stable at the falling edge
  always @(negedge clk) begin
    codeAddr_u expIp;
    logic      expTaken;
    if (!rstN) begin
      modelClear();
      checkBit("ready in reset", 1'b0, ready);
      checkBit("predValid in reset", 1'b0, predValid);
    end else begin
      // Result of the lookup taken at the previous rising edge
      if (predValid) begin
        if (expIpQ.size() == 0) begin
          errors++;
          $display("A prediction came out with no lookup accepted in %s", testName);
        end else begin
          expIp = expIpQ.pop_front();
          expTaken = expTakenQ.pop_front();
          checkAddr("predIp", expIp, predIp);
          checkBit("predTaken", expTaken, predTaken);
        end
      end else begin
        checkBit("predTaken idle", 1'b0, predTaken);
        if (expIpQ.size() != 0) begin
          errors++;
          $display("No prediction came out for an accepted lookup in %s", testName);
          expIpQ.delete();
          expTakenQ.delete();
        end
      end
      // The update lands before the lookup at the same edge reads
      if (ready && updValid) begin
        modelUpdate(updIp, updTgt, updTaken);
      end
      if (ready && lookupValid) begin
        expTaken = refPredict(lookupIp, expIp);
        expIpQ.push_back(expIp);
        expTakenQ.push_back(expTaken);
      end
    end
  end

  // Ends a run that stops making progress
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout after %0d cycles in %s", cycleCount, testName);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================

  function automatic codeAddr_u poolAddr();
    codeAddr_u   a;
    logic [31:0] r;
    // Two tags over eight indexes so entries collide often
    r = randBits(1);
    a.fields.tag = r[0] ? 20'h5a5a5 : 20'h0c3c3;
    r = randBits(3);
    a.fields.index = {7'd5, r[2:0]};
    a.fields.offset = 2'b00;
    return a;
  endfunction

  function automatic codeAddr_u randTarget();
    codeAddr_u   a;
    logic [31:0] r;
    r = randBits(30);
    a.raw = {r[29:0], 2'b00};
    return a;
  endfunction

  task automatic applyReset();
    @(posedge clk);
    rstN <= 1'b0;
    lookupValid <= 1'b0;
    updValid <= 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
  endtask

  task automatic waitSweep(input bit checkLength);
    int sweepCycles;
    sweepCycles = 0;
    @(negedge clk);
    while (!ready) begin
      sweepCycles++;
      @(negedge clk);
    end
    if (checkLength && sweepCycles != btbEntries) begin
      errors++;
      $display("error %s sweep cycles: expected %0d actual %0d", testName, btbEntries,
               sweepCycles);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      lookupValid <= 1'b0;
      updValid <= 1'b0;
    end
  endtask

  task automatic doLookup(input codeAddr_u ip);
    @(posedge clk);
    lookupValid <= 1'b1;
    lookupIp <= ip;
    updValid <= 1'b0;
  endtask

  task automatic doUpdate(input codeAddr_u ip, input codeAddr_u tgt, input logic taken);
    @(posedge clk);
    updValid <= 1'b1;
    updIp <= ip;
    updTgt <= tgt;
    updTaken <= taken;
    lookupValid <= 1'b0;
  endtask

  task automatic driveRandomCycle();
    codeAddr_u   uIp;
    codeAddr_u   uTgt;
    codeAddr_u   lIp;
    logic [31:0] rUpd;
    logic [31:0] rLook;
    logic [31:0] rTaken;
    logic [31:0] rSame;
    rUpd = randBits(1);
    rLook = randBits(2);
    uIp = poolAddr();
    uTgt = randTarget();
    rTaken = randBits(1);
    rSame = randBits(2);
    // A quarter of the lookups hit the address being updated at the same edge
    if (rSame[1:0] == 2'b00) begin
      lIp = uIp;
    end else begin
      lIp = poolAddr();
    end
    @(posedge clk);
    updValid <= rUpd[0];
    updIp <= uIp;
    updTgt <= uTgt;
    updTaken <= rTaken[0];
    lookupValid <= (rLook[1:0] != 2'b00);
    lookupIp <= lIp;
  endtask

  initial begin
    rstN = 1'b0;
    lookupValid = 1'b0;
    lookupIp = '0;
    updValid = 1'b0;
    updIp = '0;
    updTgt = '0;
    updTaken = 1'b0;
    lfsrState = lfsrSeed;
    errors = 0;
    checks = 0;
    cycleCount = 0;
    addrA.fields.tag = 20'h12345;
    addrA.fields.index = 10'd5;
    addrA.fields.offset = 2'b00;
    addrB = addrA;
    addrB.fields.tag = 20'h6789a;
    tgtA.raw = 32'h0000_8000;

    testName = "sweep";
    applyReset();
    waitSweep(1'b1);

    testName = "first lookups";
    repeat (8) doLookup(poolAddr());
    idle(2);

    // Counter climbs on taken outcomes and falls back on not taken
    testName = "counter rule";
    doLookup(addrA);
    doUpdate(addrA, tgtA, 1'b1);
    doLookup(addrA);
    doUpdate(addrA, tgtA, 1'b1);
    doLookup(addrA);
    doUpdate(addrA, tgtA, 1'b0);
    doLookup(addrA);
    doUpdate(addrA, tgtA, 1'b0);
    doLookup(addrA);
    idle(2);

    testName = "tag check";
    doUpdate(addrA, tgtA, 1'b1);
    doUpdate(addrA, tgtA, 1'b1);
    doLookup(addrB);
    doLookup(addrA);
    idle(2);

    testName = "random traffic";
    repeat (randomCycles) driveRandomCycle();
    idle(2);

    // Traffic offered during the sweep must leave no trace
    testName = "second sweep";
    applyReset();
    repeat (20) begin
      @(posedge clk);
      lookupValid <= 1'b1;
      lookupIp <= addrA;
      updValid <= 1'b1;
      updIp <= addrA;
      updTgt <= tgtA;
      updTaken <= 1'b1;
    end
    idle(1);
    waitSweep(1'b0);
    doLookup(addrA);
    doLookup(addrB);
    repeat (8) doLookup(poolAddr());
    idle(3);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
source/fetchPredictPkg.sv
source/btbIf.sv
source/counterIf.sv
source/predictCtrl.sv
source/branchTargetBuffer.sv
source/bimodalCounters.sv
source/fetchPredictor.sv
test/fetchPredictorTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the fetch predictor testbench with Verilator and runs it.
# The run counts as passed only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module fetchPredictorTb \
  -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
